//--- design/usb_out_pe_cfg.svh
// Build-time configuration of the USB OUT protocol engine
// Endpoint count, packet size, ACK timeout and the widths derived from them

`ifndef USB_OUT_PE_CFG_SVH
`define USB_OUT_PE_CFG_SVH

// Number of OUT endpoints implemented in hardware
`define USB_OUT_NUM_EPS 2

// Largest data payload accepted per packet
`define USB_OUT_MAX_PKT_BYTES 32

// Put offset width
`define USB_OUT_PKT_W ($clog2(`USB_OUT_MAX_PKT_BYTES))

// Endpoint index width, at least one bit
`define USB_OUT_EP_W (((`USB_OUT_NUM_EPS) > 1) ? $clog2(`USB_OUT_NUM_EPS) : 1)

// 17 bit times at 4 clocks per bit on the 48 MHz clock
// Wait window for the DATA packet that follows a token
`define USB_OUT_ACK_TIMEOUT 68

// Counter must hold the reload value itself
`define USB_OUT_TIMEOUT_W ($clog2(`USB_OUT_ACK_TIMEOUT + 1))

`endif

//--- design/usb_out_pkg.sv
// Shared types of the USB OUT protocol engine
// PID codes, transaction states, vector typedefs and packed structs

`include "usb_out_pe_cfg.svh"

package usb_out_pkg;

  // PID codes as seen on the wire, check bits stripped
  typedef enum logic [3:0] {
    PID_OUT   = 4'b0001,
    PID_ACK   = 4'b0010,
    PID_DATA0 = 4'b0011,
    PID_NAK   = 4'b1010,
    PID_DATA1 = 4'b1011,
    PID_SETUP = 4'b1101,
    PID_STALL = 4'b1110
  } usb_pid_e;

  // OUT transaction progress
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_RCVD_TOKEN,
    ST_DATA_START,
    ST_DATA_END
  } xact_state_e;

  // One bit per implemented endpoint
  typedef logic [`USB_OUT_NUM_EPS-1:0] ep_vec_t;
  typedef logic [3:0]                  ep_num_t;
  typedef logic [6:0]                  dev_addr_t;
  typedef logic [`USB_OUT_PKT_W-1:0]   put_addr_t;
  typedef logic [7:0]                  byte_t;

  // Single-cycle packet events from the decoder
  typedef struct packed {
    logic    out_tok;
    logic    setup_tok;
    logic    data_pkt;
    logic    bad_pkt;
    logic    data_pid1;
    logic    ep_in_hw;
    ep_num_t ep;
    logic    pkt_start;
  } rx_evt_t;

  // Static endpoint configuration and status
  typedef struct packed {
    ep_vec_t enabled;
    ep_vec_t control;
    ep_vec_t full;
    ep_vec_t stall;
  } ep_cfg_t;

endpackage

//--- design/usb_out_rx_decode.sv
// Receive-side packet classifier for the OUT protocol engine
// Token, data and bad-packet events plus the data byte register

`timescale 1ns/1ps
`include "usb_out_pe_cfg.svh"

module usb_out_rx_decode (
  input  logic                   clk_48mhz_i,
  input  logic                   rst_ni,
  input  usb_out_pkg::dev_addr_t dev_addr_i,

  // Strobes and fields from the rx packet layer
  input  logic                   rx_pkt_start_i,
  input  logic                   rx_pkt_end_i,
  input  logic                   rx_pkt_valid_i,
  input  logic [3:0]             rx_pid_i,
  input  usb_out_pkg::dev_addr_t rx_addr_i,
  input  usb_out_pkg::ep_num_t   rx_endp_i,
  input  logic                   rx_data_put_i,
  input  usb_out_pkg::byte_t     rx_data_i,

  output usb_out_pkg::rx_evt_t   rx_evt_o,
  output usb_out_pkg::byte_t     data_byte_o,
  output logic                   data_put_o
);

  usb_out_pkg::usb_pid_e rx_pid;
  logic                  good_end;
  logic                  addr_match;
  logic                  is_data_pid;
  logic                  ep_in_hw;

  assign rx_pid = usb_out_pkg::usb_pid_e'(rx_pid_i);

  ////////////////////////////////////////////////////////////////////////////
  // Packet classification
  ////////////////////////////////////////////////////////////////////////////

  // Packet ended with good CRC and PID check
  assign good_end    = rx_pkt_end_i && rx_pkt_valid_i;
  assign addr_match  = (rx_addr_i == dev_addr_i);
  assign is_data_pid = (rx_pid == usb_out_pkg::PID_DATA0) ||
                       (rx_pid == usb_out_pkg::PID_DATA1);

  // Endpoint field beyond the implemented range is ignored
  assign ep_in_hw = {1'b0, rx_endp_i} < 5'(`USB_OUT_NUM_EPS);

  always_comb begin
    rx_evt_o.out_tok   = good_end && addr_match && (rx_pid == usb_out_pkg::PID_OUT);
    rx_evt_o.setup_tok = good_end && addr_match && (rx_pid == usb_out_pkg::PID_SETUP);
    rx_evt_o.data_pkt  = good_end && is_data_pid;
    // Corrupt packet, or a valid one that is not DATA0/DATA1
    rx_evt_o.bad_pkt   = rx_pkt_end_i && (!rx_pkt_valid_i || !is_data_pid);
    // DATA1 differs from DATA0 only in the top PID bit
    rx_evt_o.data_pid1 = rx_pid_i[3];
    rx_evt_o.ep_in_hw  = ep_in_hw;
    rx_evt_o.ep        = ep_in_hw ? rx_endp_i : '0;
    rx_evt_o.pkt_start = rx_pkt_start_i;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Data byte capture
  ////////////////////////////////////////////////////////////////////////////

  // Strobe delayed by one cycle to line up with the latched byte
  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      data_put_o <= 1'b0;
    end else begin
      data_put_o <= rx_data_put_i;
    end
  end

  // Byte holds until the next put
  always_ff @(posedge clk_48mhz_i) begin
    if (rx_data_put_i) begin
      data_byte_o <= rx_data_i;
    end
  end

  // A byte never shares its cycle with the packet end
  // Its delayed put would otherwise fall outside the data phase
  put_before_end_a: assert property (
    @(posedge clk_48mhz_i) disable iff (!rst_ni)
    rx_pkt_end_i |-> !rx_data_put_i
  );

endmodule

//--- design/usb_out_put_tracker.sv
// Put address counter and NAK-pending flag
// Tracks fill state of the data packet for the current endpoint

`timescale 1ns/1ps
`include "usb_out_pe_cfg.svh"

module usb_out_put_tracker (
  input  logic                     clk_48mhz_i,
  input  logic                     rst_ni,
  input  usb_out_pkg::xact_state_e state_i,
  input  logic [`USB_OUT_EP_W-1:0] ep_idx_i,
  input  usb_out_pkg::ep_vec_t     ep_full_vec_i,
  input  logic                     data_put_i,

  output logic                     out_ep_data_put_o,
  output usb_out_pkg::put_addr_t   out_ep_put_addr_o,
  output logic                     nak_pending_o
);

  logic in_data;
  logic hold_addr;
  logic incr_addr;

  assign in_data = (state_i == usb_out_pkg::ST_DATA_START);

  // Only bytes inside the data phase reach the endpoint
  assign out_ep_data_put_o = data_put_i && in_data;

  ////////////////////////////////////////////////////////////////////////////
  // NAK tracking
  ////////////////////////////////////////////////////////////////////////////

  // Any byte that meets a full endpoint spoils the whole packet
  // Cleared between transactions and while waiting for data
  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      nak_pending_o <= 1'b0;
    end else if ((state_i == usb_out_pkg::ST_IDLE) ||
                 (state_i == usb_out_pkg::ST_RCVD_TOKEN)) begin
      nak_pending_o <= 1'b0;
    end else if (out_ep_data_put_o && ep_full_vec_i[ep_idx_i]) begin
      nak_pending_o <= 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Put address
  ////////////////////////////////////////////////////////////////////////////

  // Freeze once a NAK is certain, or at the last offset
  // Oversized packets overwrite the final byte
  assign hold_addr = nak_pending_o || (&out_ep_put_addr_o);
  assign incr_addr = out_ep_data_put_o && !hold_addr;

  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_ep_put_addr_o <= '0;
    end else if (state_i == usb_out_pkg::ST_RCVD_TOKEN) begin
      out_ep_put_addr_o <= '0;
    end else if (incr_addr) begin
      out_ep_put_addr_o <= out_ep_put_addr_o + 1'b1;
    end
  end

  // Data phase always opens on a cleared address
  put_addr_start_a: assert property (
    @(posedge clk_48mhz_i) disable iff (!rst_ni)
    ((state_i == usb_out_pkg::ST_DATA_START) &&
     !$past(state_i == usb_out_pkg::ST_DATA_START))
      |-> (out_ep_put_addr_o == '0)
  );

endmodule

//--- design/usb_out_xact_fsm.sv
// OUT/SETUP transaction state machine with ACK timeout and handshakes
// Also holds the per-endpoint data toggles and SETUP flags

`timescale 1ns/1ps
`include "usb_out_pe_cfg.svh"

module usb_out_xact_fsm (
  input  logic                     clk_48mhz_i,
  input  logic                     rst_ni,
  input  logic                     link_reset_i,
  input  usb_out_pkg::rx_evt_t     rx_evt_i,
  input  usb_out_pkg::ep_cfg_t     ep_cfg_i,
  input  logic                     nak_pending_i,

  output usb_out_pkg::xact_state_e state_o,
  output logic [`USB_OUT_EP_W-1:0] ep_idx_o,
  output usb_out_pkg::ep_num_t     out_ep_current_o,
  output logic                     out_ep_newpkt_o,
  output logic                     out_ep_acked_o,
  output logic                     out_ep_rollback_o,
  output usb_out_pkg::ep_vec_t     out_ep_setup_o,
  output usb_out_pkg::ep_vec_t     out_data_toggle_o,
  output logic                     tx_pkt_start_o,
  output logic [3:0]               tx_pid_o
);

  usb_out_pkg::xact_state_e       state_q, state_d;
  logic [`USB_OUT_EP_W-1:0]       ep_idx_d;
  logic [`USB_OUT_TIMEOUT_W-1:0]  timeout_q, timeout_d;
  usb_out_pkg::ep_vec_t           toggle_q, toggle_d;
  logic                           ep_active;
  logic                           xact_start;
  logic                           bad_toggle;
  logic                           xact_setup_q;
  logic                           ep_blocked;

  // Index of the endpoint named by the token in this cycle
  assign ep_idx_d  = rx_evt_i.ep[`USB_OUT_EP_W-1:0];
  assign ep_active = rx_evt_i.ep_in_hw && ep_cfg_i.enabled[ep_idx_d];
  // SETUP only opens a transaction on a control endpoint
  assign xact_start = (state_q == usb_out_pkg::ST_IDLE) && ep_active &&
                      (rx_evt_i.out_tok ||
                       (rx_evt_i.setup_tok && ep_cfg_i.control[ep_idx_d]));

  // Toggle check, skipped for a stalled endpoint
  assign bad_toggle = rx_evt_i.data_pkt && !ep_cfg_i.stall[ep_idx_o] &&
                      (rx_evt_i.data_pid1 != toggle_q[ep_idx_o]);

  // Data cannot be stored
  assign ep_blocked = nak_pending_i || ep_cfg_i.full[ep_idx_o];

  ////////////////////////////////////////////////////////////////////////////
  // Next state and handshake
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d           = state_q;
    timeout_d         = (`USB_OUT_TIMEOUT_W)'(`USB_OUT_ACK_TIMEOUT);
    tx_pkt_start_o    = 1'b0;
    tx_pid_o          = 4'b0000;
    out_ep_acked_o    = 1'b0;
    out_ep_rollback_o = 1'b0;

    unique case (state_q)
      usb_out_pkg::ST_IDLE: begin
        if (xact_start) begin
          state_d = usb_out_pkg::ST_RCVD_TOKEN;
        end
      end

      usb_out_pkg::ST_RCVD_TOKEN: begin
        // Host gets a fixed window to begin its DATA packet
        timeout_d = timeout_q - 1'b1;
        if (rx_evt_i.pkt_start) begin
          state_d = usb_out_pkg::ST_DATA_START;
        end else if (timeout_q == '0) begin
          state_d = usb_out_pkg::ST_IDLE;
        end
      end

      usb_out_pkg::ST_DATA_START: begin
        if (bad_toggle) begin
          // Retransmission after a lost ACK, acknowledge and drop
          state_d           = usb_out_pkg::ST_IDLE;
          out_ep_rollback_o = 1'b1;
          tx_pkt_start_o    = 1'b1;
          tx_pid_o          = usb_out_pkg::PID_ACK;
        end else if (rx_evt_i.bad_pkt) begin
          // Corrupt or unexpected packet, stay silent
          state_d           = usb_out_pkg::ST_IDLE;
          out_ep_rollback_o = 1'b1;
        end else if (rx_evt_i.data_pkt) begin
          state_d = usb_out_pkg::ST_DATA_END;
        end
      end

      usb_out_pkg::ST_DATA_END: begin
        state_d        = usb_out_pkg::ST_IDLE;
        tx_pkt_start_o = 1'b1;
        if (xact_setup_q) begin
          // A SETUP that cannot be stored gets no handshake at all
          if (ep_blocked) begin
            tx_pkt_start_o    = 1'b0;
            out_ep_rollback_o = 1'b1;
          end else begin
            tx_pid_o       = usb_out_pkg::PID_ACK;
            out_ep_acked_o = 1'b1;
          end
        end else if (ep_cfg_i.stall[ep_idx_o]) begin
          tx_pid_o = usb_out_pkg::PID_STALL;
        end else if (ep_blocked) begin
          tx_pid_o          = usb_out_pkg::PID_NAK;
          out_ep_rollback_o = 1'b1;
        end else begin
          tx_pid_o       = usb_out_pkg::PID_ACK;
          out_ep_acked_o = 1'b1;
        end
      end

      default: state_d = usb_out_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= usb_out_pkg::ST_IDLE;
      timeout_q <= (`USB_OUT_TIMEOUT_W)'(`USB_OUT_ACK_TIMEOUT);
    end else begin
      state_q   <= link_reset_i ? usb_out_pkg::ST_IDLE : state_d;
      timeout_q <= timeout_d;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Transaction context
  ////////////////////////////////////////////////////////////////////////////

  // Endpoint and kind are latched as the token is accepted
  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_ep_newpkt_o  <= 1'b0;
      out_ep_current_o <= '0;
      xact_setup_q     <= 1'b0;
    end else begin
      out_ep_newpkt_o <= xact_start;
      if (xact_start) begin
        out_ep_current_o <= rx_evt_i.ep;
        xact_setup_q     <= rx_evt_i.setup_tok;
      end
    end
  end

  // SETUP flag set by SETUP, cleared by the next OUT
  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_ep_setup_o <= '0;
    end else if (link_reset_i) begin
      out_ep_setup_o <= '0;
    end else if (xact_start) begin
      out_ep_setup_o[ep_idx_d] <= rx_evt_i.setup_tok;
    end
  end

  // SETUP restarts at DATA0, each accepted packet flips
  always_comb begin
    toggle_d = toggle_q;
    if (xact_start && rx_evt_i.setup_tok) begin
      toggle_d[ep_idx_d] = 1'b0;
    end else if (out_ep_acked_o) begin
      toggle_d[ep_idx_o] = ~toggle_q[ep_idx_o];
    end
  end

  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      toggle_q <= '0;
    end else if (link_reset_i) begin
      toggle_q <= '0;
    end else begin
      toggle_q <= toggle_d;
    end
  end

  assign state_o           = state_q;
  assign ep_idx_o          = out_ep_current_o[`USB_OUT_EP_W-1:0];
  assign out_data_toggle_o = toggle_q;

  // No NAK left over from the last packet while waiting for data
  nak_clear_at_token_a: assert property (
    @(posedge clk_48mhz_i) disable iff (!rst_ni)
    (state_q == usb_out_pkg::ST_RCVD_TOKEN) |-> !nak_pending_i
  );

endmodule

//--- design/usb_out_pe.sv
// Top level of the USB full-speed OUT/SETUP protocol engine
// Connects rx decoder, put tracker and transaction state machine

`timescale 1ns/1ps
`include "usb_out_pe_cfg.svh"

module usb_out_pe (
  input  logic                   clk_48mhz_i,
  input  logic                   rst_ni,
  input  logic                   link_reset_i,
  input  usb_out_pkg::dev_addr_t dev_addr_i,

  // Endpoint side
  input  usb_out_pkg::ep_cfg_t   ep_cfg_i,
  output usb_out_pkg::ep_num_t   out_ep_current_o,
  output logic                   out_ep_data_put_o,
  output usb_out_pkg::put_addr_t out_ep_put_addr_o,
  output usb_out_pkg::byte_t     out_ep_data_o,
  output logic                   out_ep_newpkt_o,
  output logic                   out_ep_acked_o,
  output logic                   out_ep_rollback_o,
  output usb_out_pkg::ep_vec_t   out_ep_setup_o,
  output usb_out_pkg::ep_vec_t   out_data_toggle_o,

  // Rx packet layer
  input  logic                   rx_pkt_start_i,
  input  logic                   rx_pkt_end_i,
  input  logic                   rx_pkt_valid_i,
  input  logic [3:0]             rx_pid_i,
  input  usb_out_pkg::dev_addr_t rx_addr_i,
  input  usb_out_pkg::ep_num_t   rx_endp_i,
  input  logic                   rx_data_put_i,
  input  usb_out_pkg::byte_t     rx_data_i,

  // Tx handshake request
  output logic                   tx_pkt_start_o,
  output logic [3:0]             tx_pid_o
);

  usb_out_pkg::rx_evt_t     rx_evt;
  logic                     data_put_q;
  usb_out_pkg::xact_state_e xact_state;
  logic [`USB_OUT_EP_W-1:0] ep_idx;
  logic                     nak_pending;

  usb_out_rx_decode u_rx_decode (
    .clk_48mhz_i    (clk_48mhz_i),
    .rst_ni         (rst_ni),
    .dev_addr_i     (dev_addr_i),
    .rx_pkt_start_i (rx_pkt_start_i),
    .rx_pkt_end_i   (rx_pkt_end_i),
    .rx_pkt_valid_i (rx_pkt_valid_i),
    .rx_pid_i       (rx_pid_i),
    .rx_addr_i      (rx_addr_i),
    .rx_endp_i      (rx_endp_i),
    .rx_data_put_i  (rx_data_put_i),
    .rx_data_i      (rx_data_i),
    .rx_evt_o       (rx_evt),
    .data_byte_o    (out_ep_data_o),
    .data_put_o     (data_put_q)
  );

  // Fill state follows the FSM phase and the full status of the endpoint
  usb_out_put_tracker u_put_tracker (
    .clk_48mhz_i       (clk_48mhz_i),
    .rst_ni            (rst_ni),
    .state_i           (xact_state),
    .ep_idx_i          (ep_idx),
    .ep_full_vec_i     (ep_cfg_i.full),
    .data_put_i        (data_put_q),
    .out_ep_data_put_o (out_ep_data_put_o),
    .out_ep_put_addr_o (out_ep_put_addr_o),
    .nak_pending_o     (nak_pending)
  );

  usb_out_xact_fsm u_xact_fsm (
    .clk_48mhz_i       (clk_48mhz_i),
    .rst_ni            (rst_ni),
    .link_reset_i      (link_reset_i),
    .rx_evt_i          (rx_evt),
    .ep_cfg_i          (ep_cfg_i),
    .nak_pending_i     (nak_pending),
    .state_o           (xact_state),
    .ep_idx_o          (ep_idx),
    .out_ep_current_o  (out_ep_current_o),
    .out_ep_newpkt_o   (out_ep_newpkt_o),
    .out_ep_acked_o    (out_ep_acked_o),
    .out_ep_rollback_o (out_ep_rollback_o),
    .out_ep_setup_o    (out_ep_setup_o),
    .out_data_toggle_o (out_data_toggle_o),
    .tx_pkt_start_o    (tx_pkt_start_o),
    .tx_pid_o          (tx_pid_o)
  );

endmodule

//--- verification/usb_out_pe_tb.sv
// Testbench for the USB OUT/SETUP protocol engine
// Packet-driving tasks, output monitor, directed tests and watchdog

`timescale 1ns/1ps
`include "usb_out_pe_cfg.svh"

module usb_out_pe_tb;

  localparam int RESET_CYCLES = 16;
  // Worst case per transaction: token, 8-byte data packet and handshake wait
  localparam int NUM_XACTS    = 14;
  localparam int XACT_CYCLES  = 48;
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + NUM_XACTS * XACT_CYCLES +
                                   2 * `USB_OUT_ACK_TIMEOUT + 200;
  localparam usb_out_pkg::dev_addr_t DEV_ADDR = 7'h2a;

  logic                       clk_48mhz = 1'b0;
  logic                       rst_n;
  logic                       link_reset;
  usb_out_pkg::dev_addr_t     dev_addr;
  usb_out_pkg::ep_cfg_t       ep_cfg;
  logic                       rx_pkt_start;
  logic                       rx_pkt_end;
  logic                       rx_pkt_valid;
  logic [3:0]                 rx_pid;
  usb_out_pkg::dev_addr_t     rx_addr;
  usb_out_pkg::ep_num_t       rx_endp;
  logic                       rx_data_put;
  usb_out_pkg::byte_t         rx_data;

  usb_out_pkg::ep_num_t       out_ep_current;
  logic                       out_ep_data_put;
  usb_out_pkg::put_addr_t     out_ep_put_addr;
  usb_out_pkg::byte_t         out_ep_data;
  logic                       out_ep_newpkt;
  logic                       out_ep_acked;
  logic                       out_ep_rollback;
  usb_out_pkg::ep_vec_t       out_ep_setup;
  usb_out_pkg::ep_vec_t       out_data_toggle;
  logic                       tx_pkt_start;
  logic [3:0]                 tx_pid;

  // Reference toggles, one per endpoint
  usb_out_pkg::ep_vec_t       exp_toggle;
  integer                     seed;
  int                         error_count;
  int                         check_count;

  // Monitor results of the current transaction
  int                         tx_count;
  logic [3:0]                 last_tx_pid;
  int                         acked_count;
  int                         rollback_count;
  int                         newpkt_count;
  usb_out_pkg::byte_t         sent_q[$];
  usb_out_pkg::byte_t         got_data_q[$];
  int                         got_addr_q[$];
  int                         got_cur_q[$];

  always #4 clk_48mhz = ~clk_48mhz;

  usb_out_pe u_usb_out_pe (
    .clk_48mhz_i       (clk_48mhz),
    .rst_ni            (rst_n),
    .link_reset_i      (link_reset),
    .dev_addr_i        (dev_addr),
    .ep_cfg_i          (ep_cfg),
    .out_ep_current_o  (out_ep_current),
    .out_ep_data_put_o (out_ep_data_put),
    .out_ep_put_addr_o (out_ep_put_addr),
    .out_ep_data_o     (out_ep_data),
    .out_ep_newpkt_o   (out_ep_newpkt),
    .out_ep_acked_o    (out_ep_acked),
    .out_ep_rollback_o (out_ep_rollback),
    .out_ep_setup_o    (out_ep_setup),
    .out_data_toggle_o (out_data_toggle),
    .rx_pkt_start_i    (rx_pkt_start),
    .rx_pkt_end_i      (rx_pkt_end),
    .rx_pkt_valid_i    (rx_pkt_valid),
    .rx_pid_i          (rx_pid),
    .rx_addr_i         (rx_addr),
    .rx_endp_i         (rx_endp),
    .rx_data_put_i     (rx_data_put),
    .rx_data_i         (rx_data),
    .tx_pkt_start_o    (tx_pkt_start),
    .tx_pid_o          (tx_pid)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Output monitor, sampled mid-cycle
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk_48mhz) begin
    if (rst_n) begin
      if (tx_pkt_start) begin
        tx_count++;
        last_tx_pid = tx_pid;
      end
      if (out_ep_acked) acked_count++;
      if (out_ep_rollback) rollback_count++;
      if (out_ep_newpkt) newpkt_count++;
      // Endpoint write port
      if (out_ep_data_put) begin
        got_data_q.push_back(out_ep_data);
        got_addr_q.push_back(int'(out_ep_put_addr));
        got_cur_q.push_back(int'(out_ep_current));
      end
    end
  end

  task automatic clear_monitor();
    tx_count       = 0;
    acked_count    = 0;
    rollback_count = 0;
    newpkt_count   = 0;
    sent_q.delete();
    got_data_q.delete();
    got_addr_q.delete();
    got_cur_q.delete();
  endtask

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
      $display("ERR @%0t ns: %s is %0h, expected %0h", $time, what, got, exp);
      error_count++;
    end
  endtask

  function automatic logic [3:0] data_pid_for(input logic toggle);
    return toggle ? usb_out_pkg::PID_DATA1 : usb_out_pkg::PID_DATA0;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Packet drivers
  ////////////////////////////////////////////////////////////////////////////

  task automatic send_token(input logic [3:0] pid, input usb_out_pkg::dev_addr_t addr,
                            input usb_out_pkg::ep_num_t ep);
    @(posedge clk_48mhz);
    rx_pkt_start <= 1'b1;
    @(posedge clk_48mhz);
    rx_pkt_start <= 1'b0;
    @(posedge clk_48mhz);
    rx_pkt_end   <= 1'b1;
    rx_pkt_valid <= 1'b1;
    rx_pid       <= pid;
    rx_addr      <= addr;
    rx_endp      <= ep;
    @(posedge clk_48mhz);
    rx_pkt_end   <= 1'b0;
    rx_pkt_valid <= 1'b0;
  endtask

  // Random payload, bytes on consecutive cycles, then the packet end
  task automatic send_data(input logic [3:0] pid, input int n_bytes, input logic valid);
    usb_out_pkg::byte_t b;
    int i;
    @(posedge clk_48mhz);
    rx_pkt_start <= 1'b1;
    @(posedge clk_48mhz);
    rx_pkt_start <= 1'b0;
    for (i = 0; i < n_bytes; i++) begin
      @(posedge clk_48mhz);
      b = 8'($random(seed));
      rx_data_put <= 1'b1;
      rx_data     <= b;
      sent_q.push_back(b);
    end
    @(posedge clk_48mhz);
    rx_data_put  <= 1'b0;
    rx_pkt_end   <= 1'b1;
    rx_pkt_valid <= valid;
    rx_pid       <= pid;
    @(posedge clk_48mhz);
    rx_pkt_end   <= 1'b0;
    rx_pkt_valid <= 1'b0;
  endtask

  task automatic run_xact(input logic [3:0] tok_pid, input usb_out_pkg::dev_addr_t addr,
                          input usb_out_pkg::ep_num_t ep, input logic [3:0] data_pid,
                          input int n_bytes, input logic valid);
    clear_monitor();
    send_token(tok_pid, addr, ep);
    send_data(data_pid, n_bytes, valid);
  endtask

  task automatic wait_tx(input int max_cycles);
    int cycles;
    cycles = 0;
    while ((tx_count == 0) && (cycles < max_cycles)) begin
      @(negedge clk_48mhz);
      cycles++;
    end
    if (tx_count == 0) begin
      $display("No handshake from the DUT within %0d cycles at %0t ns", max_cycles, $time);
      error_count++;
    end
    // Let the FSM settle back to idle
    repeat (2) @(negedge clk_48mhz);
  endtask

  task automatic quiet_window(input int n_cycles);
    repeat (n_cycles) @(negedge clk_48mhz);
  endtask

  task automatic check_handshake(input logic exp_tx, input logic [3:0] exp_pid,
                                 input int exp_acked, input int exp_rollback);
    check_value("handshake count", tx_count, exp_tx);
    if (exp_tx) check_value("handshake PID", last_tx_pid, exp_pid);
    check_value("acked pulses", acked_count, exp_acked);
    check_value("rollback pulses", rollback_count, exp_rollback);
    check_value("data toggles", out_data_toggle, exp_toggle);
  endtask

  task automatic check_payload(input int ep);
    int i;
    check_value("put count", got_data_q.size(), sent_q.size());
    for (i = 0; (i < sent_q.size()) && (i < got_data_q.size()); i++) begin
      check_value("put data", got_data_q[i], sent_q[i]);
      check_value("put address", got_addr_q[i], i);
      check_value("current endpoint", got_cur_q[i], ep);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic test_out_ack();
    run_xact(usb_out_pkg::PID_OUT, DEV_ADDR, 4'd1, usb_out_pkg::PID_DATA0, 8, 1'b1);
    wait_tx(16);
    exp_toggle[1] = ~exp_toggle[1];
    check_handshake(1'b1, usb_out_pkg::PID_ACK, 1, 0);
    check_value("newpkt pulses", newpkt_count, 1);
    check_payload(1);
  endtask

  // Repeated DATA0 looks like a retry after a lost ACK
  task automatic test_bad_toggle();
    run_xact(usb_out_pkg::PID_OUT, DEV_ADDR, 4'd1, usb_out_pkg::PID_DATA0, 4, 1'b1);
    wait_tx(16);
    check_handshake(1'b1, usb_out_pkg::PID_ACK, 0, 1);
  endtask

  task automatic test_full_and_stall();
    @(posedge clk_48mhz);
    ep_cfg.full[1] <= 1'b1;
    run_xact(usb_out_pkg::PID_OUT, DEV_ADDR, 4'd1, data_pid_for(exp_toggle[1]), 4, 1'b1);
    wait_tx(16);
    check_handshake(1'b1, usb_out_pkg::PID_NAK, 0, 1);
    @(posedge clk_48mhz);
    ep_cfg.full[1]  <= 1'b0;
    ep_cfg.stall[1] <= 1'b1;
    run_xact(usb_out_pkg::PID_OUT, DEV_ADDR, 4'd1, data_pid_for(exp_toggle[1]), 4, 1'b1);
    wait_tx(16);
    check_handshake(1'b1, usb_out_pkg::PID_STALL, 0, 0);
    @(posedge clk_48mhz);
    ep_cfg.stall[1] <= 1'b0;
  endtask

  task automatic test_setup();
    // Raise the ep0 toggle first so the SETUP clear is visible
    run_xact(usb_out_pkg::PID_OUT, DEV_ADDR, 4'd0, data_pid_for(exp_toggle[0]), 4, 1'b1);
    wait_tx(16);
    exp_toggle[0] = ~exp_toggle[0];
    check_handshake(1'b1, usb_out_pkg::PID_ACK, 1, 0);
    clear_monitor();
    send_token(usb_out_pkg::PID_SETUP, DEV_ADDR, 4'd0);
    @(negedge clk_48mhz);
    exp_toggle[0] = 1'b0;
    check_value("setup flags after SETUP", out_ep_setup, usb_out_pkg::ep_vec_t'(1));
    check_value("toggles after SETUP", out_data_toggle, exp_toggle);
    send_data(usb_out_pkg::PID_DATA0, 8, 1'b1);
    wait_tx(16);
    exp_toggle[0] = 1'b1;
    check_handshake(1'b1, usb_out_pkg::PID_ACK, 1, 0);
    check_payload(0);
    // Following OUT drops the SETUP flag
    clear_monitor();
    send_token(usb_out_pkg::PID_OUT, DEV_ADDR, 4'd0);
    @(negedge clk_48mhz);
    check_value("setup flags after OUT", out_ep_setup, '0);
    send_data(data_pid_for(exp_toggle[0]), 4, 1'b1);
    wait_tx(16);
    exp_toggle[0] = ~exp_toggle[0];
    check_handshake(1'b1, usb_out_pkg::PID_ACK, 1, 0);
  endtask

  task automatic test_silent();
    run_xact(usb_out_pkg::PID_OUT, DEV_ADDR ^ 7'h01, 4'd1, data_pid_for(exp_toggle[1]),
             4, 1'b1);
    quiet_window(12);
    check_handshake(1'b0, usb_out_pkg::PID_ACK, 0, 0);
    check_value("newpkt on foreign address", newpkt_count, 0);
    // First endpoint number beyond the implemented range
    run_xact(usb_out_pkg::PID_OUT, DEV_ADDR, 4'(`USB_OUT_NUM_EPS), data_pid_for(exp_toggle[0]),
             4, 1'b1);
    quiet_window(12);
    check_handshake(1'b0, usb_out_pkg::PID_ACK, 0, 0);
    check_value("newpkt on missing endpoint", newpkt_count, 0);
    // Token with no data phase runs into the ACK timeout
    clear_monitor();
    send_token(usb_out_pkg::PID_OUT, DEV_ADDR, 4'd1);
    quiet_window(`USB_OUT_ACK_TIMEOUT + 8);
    check_handshake(1'b0, usb_out_pkg::PID_ACK, 0, 0);
    check_value("newpkt before timeout", newpkt_count, 1);
    // Back in idle, so a fresh transaction is answered
    run_xact(usb_out_pkg::PID_OUT, DEV_ADDR, 4'd1, data_pid_for(exp_toggle[1]), 4, 1'b1);
    wait_tx(16);
    exp_toggle[1] = ~exp_toggle[1];
    check_handshake(1'b1, usb_out_pkg::PID_ACK, 1, 0);
    // CRC error on the data packet
    run_xact(usb_out_pkg::PID_OUT, DEV_ADDR, 4'd1, data_pid_for(exp_toggle[1]), 4, 1'b0);
    quiet_window(12);
    check_handshake(1'b0, usb_out_pkg::PID_ACK, 0, 1);
  endtask

  task automatic test_link_reset();
    run_xact(usb_out_pkg::PID_OUT, DEV_ADDR, 4'd1, data_pid_for(exp_toggle[1]), 4, 1'b1);
    wait_tx(16);
    exp_toggle[1] = ~exp_toggle[1];
    check_handshake(1'b1, usb_out_pkg::PID_ACK, 1, 0);
    run_xact(usb_out_pkg::PID_SETUP, DEV_ADDR, 4'd0, usb_out_pkg::PID_DATA0, 4, 1'b1);
    wait_tx(16);
    exp_toggle[0] = 1'b1;
    check_handshake(1'b1, usb_out_pkg::PID_ACK, 1, 0);
    check_value("setup flags before link reset", out_ep_setup, usb_out_pkg::ep_vec_t'(1));
    @(posedge clk_48mhz);
    link_reset <= 1'b1;
    @(posedge clk_48mhz);
    link_reset <= 1'b0;
    @(negedge clk_48mhz);
    exp_toggle = '0;
    check_value("toggles after link reset", out_data_toggle, exp_toggle);
    check_value("setup flags after link reset", out_ep_setup, '0);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    seed           = 49749;
    error_count    = 0;
    check_count    = 0;
    exp_toggle     = '0;
    rst_n          = 1'b0;
    link_reset     = 1'b0;
    dev_addr       = DEV_ADDR;
    ep_cfg.enabled = '1;
    ep_cfg.control = usb_out_pkg::ep_vec_t'(1);
    ep_cfg.full    = '0;
    ep_cfg.stall   = '0;
    rx_pkt_start   = 1'b0;
    rx_pkt_end     = 1'b0;
    rx_pkt_valid   = 1'b0;
    rx_pid         = 4'b0000;
    rx_addr        = '0;
    rx_endp        = '0;
    rx_data_put    = 1'b0;
    rx_data        = '0;
    clear_monitor();
    repeat (RESET_CYCLES) @(posedge clk_48mhz);
    rst_n <= 1'b1;
    repeat (2) @(posedge clk_48mhz);

    test_out_ack();
    test_bad_toggle();
    test_full_and_stall();
    test_setup();
    test_silent();
    test_link_reset();

    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_48mhz);
    $display("Watchdog expired: tests did not complete within %0d cycles", WATCHDOG_CYCLES);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

//--- usb_out_pe.f
+incdir+design
design/usb_out_pkg.sv
design/usb_out_rx_decode.sv
design/usb_out_put_tracker.sv
design/usb_out_xact_fsm.sv
design/usb_out_pe.sv
verification/usb_out_pe_tb.sv

//--- Bender.yml
package:
  name: usb_out_pe

export_include_dirs:
  - design

sources:
  # RTL in compile order
  - include_dirs:
      - design
    files:
      - design/usb_out_pkg.sv
      - design/usb_out_rx_decode.sv
      - design/usb_out_put_tracker.sv
      - design/usb_out_xact_fsm.sv
      - design/usb_out_pe.sv

  # Testbench
  - target: test
    include_dirs:
      - design
    files:
      - verification/usb_out_pe_tb.sv
